/* verilog/mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// System side byte address and data word
`define MEM_ADDR_W 20
`define MEM_DATA_W 16

// Word address on the shared pads
`define MEM_PAD_ADDR_W 21

// Everything from this byte address upwards is flash
`define MEM_FLASH_BASE 20'hC0000

// Extra clocks per flash chip cycle
`define MEM_FLASH_WAIT 3

`endif

/* verilog/mem_bus_pkg.sv */
`default_nettype none

`include "mem_params.svh"

package mem_bus_pkg;

  typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;  // Byte address
  typedef logic [`MEM_DATA_W-1:0] mem_word_t;  // Data word
  typedef logic [7:0]             mem_byte_t;  // One byte lane
  typedef logic [4:0]             mem_step_t;  // Self-test step number

  // Request from a bus master
  typedef struct packed {
    logic      stb;       // Request valid
    logic      we;        // Write
    logic      byte_sel;  // Byte access
    mem_addr_t addr;
    mem_word_t wdata;
  } mem_req_t;

  // Response from the controller
  typedef struct packed {
    logic      ack;    // Single cycle
    mem_word_t rdata;  // Valid with ack
  } mem_rsp_t;

  typedef struct packed {
    logic      busy;
    logic      done;
    logic      fail;
    mem_step_t step;  // First failing step
  } mem_status_t;

endpackage

`default_nettype wire

/* verilog/mem_pad_pkg.sv */
`default_nettype none

`include "mem_params.svh"

package mem_pad_pkg;

  import mem_bus_pkg::*;

  typedef logic [`MEM_PAD_ADDR_W-1:0] pad_addr_t;  // Word address
  typedef logic [1:0]                 pad_ben_t;   // Active low with bit 1 on the high lane

  // Everything the controller drives towards the shared pads
  typedef struct packed {
    pad_addr_t addr;
    mem_word_t data;        // Write data
    logic      data_oe;     // Drive data pins
    logic      oe_n;
    logic      we_n;
    pad_ben_t  ben_n;
    logic      sram_cen_n;
    logic      flash_ce2;
  } mem_pad_out_t;

endpackage

`default_nettype wire

/* verilog/mem_ctrl.sv */
`default_nettype none

`include "mem_params.svh"

module mem_ctrl (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire mem_bus_pkg::mem_req_t      req_i,
  output mem_bus_pkg::mem_rsp_t           rsp_o,
  input  wire mem_bus_pkg::mem_word_t     pad_data_i,
  output mem_pad_pkg::mem_pad_out_t       pad_o
);

  import mem_bus_pkg::*;
  import mem_pad_pkg::*;

  localparam int wait_w = $clog2(`MEM_FLASH_WAIT + 1);
  localparam mem_addr_t flash_base = `MEM_FLASH_BASE;
  localparam mem_pad_out_t pad_idle = '{
    addr:       '0,
    data:       '0,
    data_oe:    1'b0,
    oe_n:       1'b1,
    we_n:       1'b1,
    ben_n:      2'b11,
    sram_cen_n: 1'b1,
    flash_ce2:  1'b0
  };

  typedef enum logic [2:0] {
    st_idle,
    st_setup,
    st_flash_wait,
    st_latch,
    st_second
  } state_t;

  state_t            state_q;
  logic              we_q;
  logic              byte_q;
  logic              odd_q;
  logic              flash_q;
  logic              second_q;    // Working on word n+1
  logic [wait_w-1:0] wait_q;
  mem_pad_out_t      pad_q;
  mem_word_t         wdata_q;
  mem_byte_t         lo_q;        // Low byte of a split read

  logic              req_flash;
  mem_addr_t         req_off;
  pad_addr_t         req_word;
  logic              req_lane;    // Single lane in the first chip cycle
  logic              split;
  logic              last;
  mem_byte_t         rd_lane;
  mem_word_t         rdata;

  // Address decode of the incoming request
  assign req_flash = (req_i.addr >= flash_base);
  assign req_off   = req_flash ? req_i.addr - flash_base : req_i.addr;
  assign req_word  = pad_addr_t'(req_off[`MEM_ADDR_W-1:1]);
  assign req_lane  = req_i.byte_sel || req_i.addr[0];

  assign split = odd_q && !byte_q;
  assign last  = (state_q == st_latch) && (second_q || !split);

  // Read data straight from the pins in the last cycle
  always_comb begin
    rd_lane = odd_q ? pad_data_i[15:8] : pad_data_i[7:0];
    if (byte_q) begin
      rdata = {{8{rd_lane[7]}}, rd_lane};  // Sign extension
    end else if (odd_q) begin
      rdata = {pad_data_i[7:0], lo_q};     // High byte from word n+1
    end else begin
      rdata = pad_data_i;
    end
  end

  assign rsp_o = '{ack: last, rdata: rdata};
  assign pad_o = pad_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= st_idle;
      pad_q    <= pad_idle;
      we_q     <= 1'b0;
      byte_q   <= 1'b0;
      odd_q    <= 1'b0;
      flash_q  <= 1'b0;
      second_q <= 1'b0;
      wait_q   <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          if (req_i.stb) begin
            state_q          <= st_setup;
            we_q             <= req_i.we;
            byte_q           <= req_i.byte_sel;
            odd_q            <= req_i.addr[0];
            flash_q          <= req_flash;
            second_q         <= 1'b0;
            pad_q.addr       <= req_word;
            pad_q.sram_cen_n <= req_flash;
            pad_q.flash_ce2  <= req_flash;
            pad_q.oe_n       <= req_i.we;
            pad_q.data_oe    <= req_i.we && !req_flash;  // Flash writes are dropped
            pad_q.data       <= req_lane ? {2{req_i.wdata[7:0]}} : req_i.wdata;
            pad_q.ben_n      <= !req_lane ? 2'b00 : (req_i.addr[0] ? 2'b01 : 2'b10);
          end
        end
        st_setup, st_second: begin
          if (flash_q) begin
            state_q <= st_flash_wait;
            wait_q  <= wait_w'(`MEM_FLASH_WAIT - 1);
          end else begin
            state_q    <= st_latch;
            pad_q.we_n <= !we_q;  // Write strobe only in the last cycle
          end
        end
        st_flash_wait: begin
          if (wait_q == '0) begin
            state_q <= st_latch;
          end else begin
            wait_q <= wait_q - 1'b1;
          end
        end
        st_latch: begin
          if (split && !second_q) begin
            // Move to the low lane of word n+1
            state_q     <= st_second;
            second_q    <= 1'b1;
            pad_q.we_n  <= 1'b1;
            pad_q.addr  <= pad_q.addr + 1'b1;
            pad_q.ben_n <= 2'b10;
            pad_q.data  <= {2{wdata_q[15:8]}};
          end else begin
            state_q <= st_idle;
            pad_q   <= pad_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == st_idle && req_i.stb) begin
      wdata_q <= req_i.wdata;
    end
    if (state_q == st_latch && split && !second_q) begin
      lo_q <= pad_data_i[15:8];  // Odd byte of word n
    end
  end

endmodule

`default_nettype wire

/* verilog/mem_self_test.sv */
`default_nettype none

`include "mem_params.svh"

module mem_self_test (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     start_i,
  input  wire mem_bus_pkg::mem_req_t    host_req_i,
  output mem_bus_pkg::mem_rsp_t         host_rsp_o,
  output mem_bus_pkg::mem_req_t         ctrl_req_o,
  input  wire mem_bus_pkg::mem_rsp_t    ctrl_rsp_i,
  output mem_bus_pkg::mem_status_t      status_o
);

  import mem_bus_pkg::*;

  localparam mem_addr_t flash_base = `MEM_FLASH_BASE;

  // Encodings equal the reported step numbers
  typedef enum logic [4:0] {
    st_idle, st_rd_v1, st_rd_v2, st_wr_v2, st_wr_v1, st_rd_b1, st_wr_b1,
    st_rd_b2, st_wr_b2, st_wb_v1, st_rd_v3, st_wr_v3, st_rd_v4, st_wr_v4,
    st_ck_04, st_ck_02, st_ck_10, st_ck_14, st_ck_1a, st_ck_1c, st_ck_19
  } step_t;

  step_t     step_q;
  logic      busy_q;
  logic      done_q;
  logic      fail_q;
  mem_step_t fail_step_q;
  logic      arm_q;       // Start seen while a host access was in flight
  logic      host_act_q;  // Controller is serving the host
  mem_word_t v1_q;
  mem_word_t v2_q;
  mem_word_t b1_q;
  mem_word_t b2_q;
  mem_word_t v3_q;
  mem_word_t v4_q;

  logic      go;
  logic      is_check;
  mem_req_t  self_req;
  mem_word_t exp_word;

  function automatic mem_req_t rd_req(mem_addr_t addr, logic byte_sel);
    return '{stb: 1'b1, we: 1'b0, byte_sel: byte_sel, addr: addr, wdata: '0};
  endfunction

  function automatic mem_req_t wr_req(mem_addr_t addr, logic byte_sel, mem_word_t data);
    return '{stb: 1'b1, we: 1'b1, byte_sel: byte_sel, addr: addr, wdata: data};
  endfunction

  assign go       = !busy_q && (start_i || arm_q);
  assign is_check = (step_q >= st_ck_04);

  // Copy script
  always_comb begin
    case (step_q)
      st_rd_v1: self_req = rd_req(flash_base + 20'h02, 1'b0);
      st_rd_v2: self_req = rd_req(flash_base + 20'h04, 1'b0);
      st_wr_v2: self_req = wr_req(20'h04, 1'b0, v2_q);
      st_wr_v1: self_req = wr_req(20'h02, 1'b0, v1_q);
      st_rd_b1: self_req = rd_req(flash_base + 20'h40, 1'b1);
      st_wr_b1: self_req = wr_req(20'h10, 1'b0, b1_q);
      st_rd_b2: self_req = rd_req(flash_base + 20'h31, 1'b1);
      st_wr_b2: self_req = wr_req(20'h14, 1'b0, b2_q);
      st_wb_v1: self_req = wr_req(20'h19, 1'b1, v1_q);  // Odd lane byte write
      st_rd_v3: self_req = rd_req(flash_base + 20'h03, 1'b0);
      st_wr_v3: self_req = wr_req(20'h1a, 1'b0, v3_q);
      st_rd_v4: self_req = rd_req(20'h03, 1'b0);  // Split across words 1 and 2
      st_wr_v4: self_req = wr_req(20'h1c, 1'b0, v4_q);
      st_ck_04: self_req = rd_req(20'h04, 1'b0);
      st_ck_02: self_req = rd_req(20'h02, 1'b0);
      st_ck_10: self_req = rd_req(20'h10, 1'b0);
      st_ck_14: self_req = rd_req(20'h14, 1'b0);
      st_ck_1a: self_req = rd_req(20'h1a, 1'b0);
      st_ck_1c: self_req = rd_req(20'h1c, 1'b0);
      st_ck_19: self_req = rd_req(20'h19, 1'b1);
      default:  self_req = '0;
    endcase
  end

  // Expected read data of the verify steps
  always_comb begin
    case (step_q)
      st_ck_04: exp_word = v2_q;
      st_ck_02: exp_word = v1_q;
      st_ck_10: exp_word = b1_q;
      st_ck_14: exp_word = b2_q;
      st_ck_1a: exp_word = v3_q;
      st_ck_1c: exp_word = v4_q;
      default:  exp_word = {{8{v1_q[7]}}, v1_q[7:0]};
    endcase
  end

  // Bus ownership with the host held off while busy
  always_comb begin
    if (busy_q) begin
      ctrl_req_o = self_req;
      host_rsp_o = '{ack: 1'b0, rdata: ctrl_rsp_i.rdata};
    end else begin
      ctrl_req_o     = host_req_i;
      ctrl_req_o.stb = host_req_i.stb && !go;  // Keep a new host request pending
      host_rsp_o     = ctrl_rsp_i;
    end
  end

  assign status_o = '{busy: busy_q, done: done_q, fail: fail_q, step: fail_step_q};

  always_ff @(posedge clk) begin
    if (rst) begin
      step_q      <= st_idle;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      fail_q      <= 1'b0;
      fail_step_q <= '0;
      arm_q       <= 1'b0;
      host_act_q  <= 1'b0;
    end else begin
      arm_q      <= go && host_act_q;
      host_act_q <= !busy_q && !ctrl_rsp_i.ack && (host_act_q || (host_req_i.stb && !go));
      if (go && !host_act_q) begin
        busy_q      <= 1'b1;
        done_q      <= 1'b0;
        fail_q      <= 1'b0;
        fail_step_q <= '0;
        step_q      <= st_rd_v1;
      end else if (busy_q && ctrl_rsp_i.ack) begin
        if (is_check && !fail_q && ctrl_rsp_i.rdata != exp_word) begin
          fail_q      <= 1'b1;
          fail_step_q <= mem_step_t'(step_q);
        end
        if (step_q == st_ck_19) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
          step_q <= st_idle;
        end else begin
          step_q <= step_t'(step_q + 1'b1);
        end
      end
    end
  end

  // Values read back during the copy
  always_ff @(posedge clk) begin
    if (busy_q && ctrl_rsp_i.ack) begin
      case (step_q)
        st_rd_v1: v1_q <= ctrl_rsp_i.rdata;
        st_rd_v2: v2_q <= ctrl_rsp_i.rdata;
        st_rd_b1: b1_q <= ctrl_rsp_i.rdata;
        st_rd_b2: b2_q <= ctrl_rsp_i.rdata;
        st_rd_v3: v3_q <= ctrl_rsp_i.rdata;
        st_rd_v4: v4_q <= ctrl_rsp_i.rdata;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/mem_test_top.sv */
`default_nettype none

module mem_test_top (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     start_i,
  input  wire mem_bus_pkg::mem_req_t    host_req_i,
  output mem_bus_pkg::mem_rsp_t         host_rsp_o,
  output mem_bus_pkg::mem_status_t      status_o,
  output mem_pad_pkg::pad_addr_t        mem_addr_o,
  output logic                          mem_oe_n_o,
  output logic                          mem_we_n_o,
  output mem_pad_pkg::pad_ben_t         mem_ben_n_o,
  output logic                          sram_cen_n_o,
  output logic                          flash_ce2_o,
  inout  wire mem_bus_pkg::mem_word_t   mem_data_io
);

  import mem_bus_pkg::*;
  import mem_pad_pkg::*;

  mem_req_t     ctrl_req;
  mem_rsp_t     ctrl_rsp;
  mem_pad_out_t pad;

  mem_self_test u_self_test (
    .clk        (clk),
    .rst        (rst),
    .start_i    (start_i),
    .host_req_i (host_req_i),
    .host_rsp_o (host_rsp_o),
    .ctrl_req_o (ctrl_req),
    .ctrl_rsp_i (ctrl_rsp),
    .status_o   (status_o)
  );

  mem_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .req_i      (ctrl_req),
    .rsp_o      (ctrl_rsp),
    .pad_data_i (mem_data_io),  // Pin value read back
    .pad_o      (pad)
  );

  // Shared data pins
  assign mem_data_io = pad.data_oe ? pad.data : 'z;

  assign mem_addr_o   = pad.addr;
  assign mem_oe_n_o   = pad.oe_n;
  assign mem_we_n_o   = pad.we_n;
  assign mem_ben_n_o  = pad.ben_n;
  assign sram_cen_n_o = pad.sram_cen_n;
  assign flash_ce2_o  = pad.flash_ce2;

endmodule

`default_nettype wire

/* tests/mem_chip_model.sv */
`default_nettype none

module mem_chip_model (
  input  wire mem_pad_pkg::pad_addr_t  addr_i,
  input  wire logic                    oe_n_i,
  input  wire logic                    we_n_i,
  input  wire mem_pad_pkg::pad_ben_t   ben_n_i,
  input  wire logic                    sram_cen_n_i,
  input  wire logic                    flash_ce2_i,
  inout  wire mem_bus_pkg::mem_word_t  data_io
);

  import mem_bus_pkg::*;

  localparam int sram_words = 4096;

  mem_word_t sram [sram_words];
  mem_word_t rd_word;
  logic      rd_en;

  // Flash content follows a fixed byte pattern
  function automatic mem_byte_t flash_byte(input int unsigned off);
    return mem_byte_t'(off * 32'h1d + 32'd3);
  endfunction

  initial begin
    for (int i = 0; i < sram_words; i++) begin
      sram[i] = '0;
    end
  end

  // Address, lanes and data settle a cycle before the strobe falls
  always @(negedge we_n_i) begin
    if (!sram_cen_n_i) begin
      if (!ben_n_i[0]) sram[addr_i[11:0]][7:0] <= data_io[7:0];
      if (!ben_n_i[1]) sram[addr_i[11:0]][15:8] <= data_io[15:8];
    end
  end

  always @* begin
    rd_word = '0;
    rd_en   = 1'b0;
    if (!sram_cen_n_i && !oe_n_i && we_n_i) begin
      rd_word = sram[addr_i[11:0]];
      rd_en   = 1'b1;
    end else if (flash_ce2_i && !oe_n_i) begin
      rd_word = {flash_byte(2 * addr_i + 1), flash_byte(2 * addr_i)};  // Word n is bytes 2n, 2n+1
      rd_en   = 1'b1;
    end
  end

  assign data_io = rd_en ? rd_word : 'z;

endmodule

`default_nettype wire

/* tests/mem_test_properties.sv */
`default_nettype none

module mem_test_properties (
  input wire logic                       clk,
  input wire logic                       rst,
  input wire mem_bus_pkg::mem_rsp_t      rsp_i,
  input wire mem_pad_pkg::mem_pad_out_t  pad_i
);

  int unsigned fail_count = 0;  // Watched by the testbench

  ack_single: assert property (@(posedge clk) disable iff (rst) rsp_i.ack |=> !rsp_i.ack)
    else begin
      fail_count++;
      $error("ack held high for more than one cycle");
    end

  oe_we_exclusive: assert property (@(posedge clk) disable iff (rst) pad_i.oe_n || pad_i.we_n)
    else begin
      fail_count++;
      $error("oe_n and we_n low together");
    end

  chip_exclusive: assert property (@(posedge clk) disable iff (rst)
    pad_i.sram_cen_n || !pad_i.flash_ce2)
    else begin
      fail_count++;
      $error("SRAM and flash selected together");
    end

  // Pads return to idle once reset has been seen
  idle_after_rst: assert property (@(posedge clk) rst |=>
    (pad_i.oe_n && pad_i.we_n && pad_i.ben_n == 2'b11 && pad_i.sram_cen_n &&
     !pad_i.flash_ce2 && !pad_i.data_oe && !rsp_i.ack))
    else begin
      fail_count++;
      $error("pads not idle after reset");
    end

endmodule

bind mem_ctrl mem_test_properties u_props (
  .clk   (clk),
  .rst   (rst),
  .rsp_i (rsp_o),
  .pad_i (pad_o)
);

`default_nettype wire

/* tests/mem_test_tb.sv */
`default_nettype none

`include "mem_params.svh"

module mem_test_tb;

  import mem_bus_pkg::*;
  import mem_pad_pkg::*;

  localparam mem_addr_t flash_base = `MEM_FLASH_BASE;
  localparam int        ram_bytes  = 1024;

  logic        clk;
  logic        rst;
  logic        start;
  mem_req_t    host_req;
  mem_rsp_t    host_rsp;
  mem_status_t status;
  pad_addr_t   mem_addr;
  logic        mem_oe_n;
  logic        mem_we_n;
  pad_ben_t    mem_ben_n;
  logic        sram_cen_n;
  logic        flash_ce2;
  wire mem_word_t mem_data;

  mem_byte_t   shadow [ram_bytes];  // Byte image of the low SRAM
  int          seed = 95;

  mem_test_top uut (
    .clk          (clk),
    .rst          (rst),
    .start_i      (start),
    .host_req_i   (host_req),
    .host_rsp_o   (host_rsp),
    .status_o     (status),
    .mem_addr_o   (mem_addr),
    .mem_oe_n_o   (mem_oe_n),
    .mem_we_n_o   (mem_we_n),
    .mem_ben_n_o  (mem_ben_n),
    .sram_cen_n_o (sram_cen_n),
    .flash_ce2_o  (flash_ce2),
    .mem_data_io  (mem_data)
  );

  mem_chip_model u_chips (
    .addr_i       (mem_addr),
    .oe_n_i       (mem_oe_n),
    .we_n_i       (mem_we_n),
    .ben_n_i      (mem_ben_n),
    .sram_cen_n_i (sram_cen_n),
    .flash_ce2_i  (flash_ce2),
    .data_io      (mem_data)
  );

  always #5 clk = ~clk;

  function automatic mem_byte_t expected_flash_byte(input int unsigned off);
    return mem_byte_t'(off * 32'h1d + 32'd3);
  endfunction

  // Little endian word at any byte offset
  function automatic mem_word_t flash_word(input int unsigned off);
    return {expected_flash_byte(off + 1), expected_flash_byte(off)};
  endfunction

  function automatic mem_word_t sign_extend(input mem_byte_t b);
    return {{8{b[7]}}, b};
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input mem_word_t got, input mem_word_t exp);
    if (got !== exp) abort_run($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_status(input mem_status_t got, input mem_status_t exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED status_o: got %h expected %h", got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) abort_run($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_ben(input string name, input pad_ben_t got, input pad_ben_t exp);
    if (got !== exp) abort_run($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
  endtask

  // One host transfer that drops stb in the cycle after ack
  task automatic bus_access(input logic we, input logic byte_sel, input mem_addr_t addr,
                            input mem_word_t wdata, input int limit, output mem_word_t rdata);
    int   cycles;
    logic acked;
    cycles = 0;
    acked  = 1'b0;
    @(posedge clk);
    #1;
    host_req = '{stb: 1'b1, we: we, byte_sel: byte_sel, addr: addr, wdata: wdata};
    while (!acked) begin
      @(negedge clk);
      if (host_rsp.ack) begin
        if (status.busy) abort_run("host ack seen while the self-test was busy");
        acked = 1'b1;
        rdata = host_rsp.rdata;
      end else begin
        cycles++;
        if (cycles > limit) abort_run($sformatf("no host ack for address %h in time", addr));
      end
    end
    @(posedge clk);
    #1;
    host_req = '0;
  endtask

  task automatic host_write(input mem_addr_t addr, input logic byte_sel, input mem_word_t data);
    mem_word_t ignored_rdata;
    bus_access(1'b1, byte_sel, addr, data, 50, ignored_rdata);
    if (addr < ram_bytes - 1) begin
      shadow[addr] = data[7:0];
      if (!byte_sel) shadow[addr + 1] = data[15:8];  // Odd words spill into word n+1
    end
  endtask

  task automatic host_read(input mem_addr_t addr, input logic byte_sel, output mem_word_t data);
    bus_access(1'b0, byte_sel, addr, '0, 50, data);
  endtask

  task automatic read_and_check(input string name, input mem_addr_t addr, input logic byte_sel,
                                input mem_word_t exp);
    mem_word_t rd;
    host_read(addr, byte_sel, rd);
    check_word($sformatf("host_rsp_o.rdata for %s", name), rd, exp);
  endtask

  task automatic wait_for_busy();
    int cycles;
    cycles = 0;
    while (!status.busy) begin
      @(negedge clk);
      cycles++;
      if (cycles > 20) abort_run("self-test did not become busy after start");
    end
  endtask

  task automatic reset_idle_test();
    @(negedge clk);
    check_bit("mem_oe_n_o", mem_oe_n, 1'b1);
    check_bit("mem_we_n_o", mem_we_n, 1'b1);
    check_ben("mem_ben_n_o", mem_ben_n, 2'b11);
    check_bit("sram_cen_n_o", sram_cen_n, 1'b1);
    check_bit("flash_ce2_o", flash_ce2, 1'b0);
    check_bit("host_rsp_o.ack", host_rsp.ack, 1'b0);
    check_word("mem_data_io", mem_data, 'z);  // Nobody drives the pins
    check_status(status, '0);
    host_write(20'h40, 1'b0, 16'h1234);
    read_and_check("RAM 40 word", 20'h40, 1'b0, 16'h1234);
  endtask

  // Host read of RAM 02 waits behind the whole self-test
  task automatic self_test_block_test();
    mem_word_t rd;
    fork
      begin
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        wait_for_busy();
      end
      bus_access(1'b0, 1'b0, 20'h02, '0, 1000, rd);
    join
    check_status(status, '{busy: 1'b0, done: 1'b1, fail: 1'b0, step: '0});
    check_word("host_rsp_o.rdata for RAM 02 held read", rd, flash_word(2));
  endtask

  task automatic copied_values_test();
    mem_word_t v1;
    mem_word_t v2;
    mem_word_t v3;
    mem_word_t v4;
    v1 = flash_word(2);
    v2 = flash_word(4);
    v3 = flash_word(3);
    v4 = {v2[7:0], v1[15:8]};  // RAM bytes 3 and 4
    read_and_check("RAM 02 word", 20'h02, 1'b0, v1);
    read_and_check("RAM 04 word", 20'h04, 1'b0, v2);
    read_and_check("RAM 10 word", 20'h10, 1'b0, sign_extend(expected_flash_byte('h40)));
    read_and_check("RAM 14 word", 20'h14, 1'b0, sign_extend(expected_flash_byte('h31)));
    read_and_check("RAM 1A word", 20'h1a, 1'b0, v3);
    read_and_check("RAM 1C word", 20'h1c, 1'b0, v4);
    read_and_check("RAM 19 byte", 20'h19, 1'b1, sign_extend(v1[7:0]));
  endtask

  task automatic random_sram_test();
    mem_addr_t addr;
    mem_addr_t wr_addr [16];
    logic      byte_sel;
    mem_word_t data;
    for (int i = 0; i < 16; i++) begin
      addr       = 20'h200 + mem_addr_t'(($random(seed) & 32'hfe) + i % 2);
      byte_sel   = i[1];
      data       = mem_word_t'($random(seed));
      wr_addr[i] = addr;
      host_write(addr, byte_sel, data);
    end
    // Every written location read back as a word and as a byte
    for (int i = 0; i < 16; i++) begin
      addr = wr_addr[i];
      read_and_check($sformatf("RAM %h word", addr), addr, 1'b0,
                     {shadow[addr + 1], shadow[addr]});
      read_and_check($sformatf("RAM %h byte", addr), addr, 1'b1, sign_extend(shadow[addr]));
    end
  endtask

  task automatic flash_read_test();
    int unsigned off;
    for (int i = 0; i < 12; i++) begin
      off = (i < 8) ? i : ($random(seed) & 32'h3fff);
      read_and_check($sformatf("flash word %h", off), flash_base + off, 1'b0, flash_word(off));
      read_and_check($sformatf("flash byte %h", off), flash_base + off, 1'b1,
                     sign_extend(expected_flash_byte(off)));
    end
    host_write(flash_base + 20'h10, 1'b0, 16'hbeef);  // Dropped by the controller
    read_and_check("flash word 10 after write", flash_base + 20'h10, 1'b0, flash_word('h10));
  endtask

  always @(negedge clk) begin
    if (uut.u_ctrl.u_props.fail_count != 0) abort_run("a bound assertion on mem_ctrl failed");
  end

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    start    = 1'b0;
    host_req = '0;
    for (int i = 0; i < ram_bytes; i++) begin
      shadow[i] = '0;
    end
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_idle_test();
    self_test_block_test();
    copied_values_test();
    random_sram_test();
    flash_read_test();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* mem_test_top.f */
+incdir+verilog
verilog/mem_bus_pkg.sv
verilog/mem_pad_pkg.sv
verilog/mem_ctrl.sv
verilog/mem_self_test.sv
verilog/mem_test_top.sv
tests/mem_chip_model.sv
tests/mem_test_properties.sv
tests/mem_test_tb.sv

/* Bender.yml */
package:
  name: mem_test

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/mem_bus_pkg.sv
      - verilog/mem_pad_pkg.sv
      - verilog/mem_ctrl.sv
      - verilog/mem_self_test.sv
      - verilog/mem_test_top.sv
  - target: test
    files:
      - tests/mem_chip_model.sv
      - tests/mem_test_properties.sv
      - tests/mem_test_tb.sv
